//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module control_unit_tb \
		-f control_unit.f -Mdir obj_dir

run: compile
	./obj_dir/Vcontrol_unit_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test failed" sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- control_unit.f
hdl/cu_pkg.sv
hdl/instr_decoder.sv
hdl/skip_sequencer.sv
hdl/skip_timer.sv
hdl/control_unit.sv
testbench/control_unit_chk.sv
testbench/control_unit_tb.sv

//--- hdl/control_unit.sv
`timescale 1ns/100ps

module control_unit #(
    parameter int SKIP_LEN = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cu_pkg::OPCODE_W-1:0]  opcode,
    input  logic                         z,
    input  logic                         n,
    input  logic                         irq,
    input  logic [cu_pkg::PORT_W-1:0]    port,
    output cu_pkg::ctrl_word_t           ctrl
);

    logic skip_req;
    logic skip_active;
    logic timer_start;
    logic timer_done;

    instr_decoder u_decoder (
        .rst         (rst),
        .opcode      (opcode),
        .z           (z),
        .n           (n),
        .irq         (irq),
        .port        (port),
        .skip_active (skip_active),
        .ctrl        (ctrl),
        .skip_req    (skip_req)
    );

    skip_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .skip_req    (skip_req),
        .irq         (irq),
        .timer_done  (timer_done),
        .skip_active (skip_active),
        .timer_start (timer_start)
    );

    // Interrupt cycles freeze the skip count
    skip_timer #(
        .SKIP_LEN (SKIP_LEN)
    ) u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (timer_start),
        .hold  (irq),
        .done  (timer_done)
    );

endmodule

//--- hdl/cu_pkg.sv
package cu_pkg;

    localparam int OPCODE_W      = 6;
    localparam int PORT_W        = 4;
    localparam int NUM_OUT_PORTS = 4;
    localparam int ALU_OP_W      = 3;

    // Fill bits that round the control word up to 24
    localparam int CTRL_SPARE_W  = 6;

    // Fixed 6-bit opcodes; ALU, LOAD and OUTI carry operands in their low bits
    typedef enum logic [OPCODE_W-1:0] {
        op_jmp  = 6'b110000,
        op_jz   = 6'b110001,
        op_jnz  = 6'b110010,
        op_jn   = 6'b110011,
        op_call = 6'b110100,
        op_ret  = 6'b110101,
        op_skz  = 6'b110110,
        op_sknz = 6'b110111,
        op_reti = 6'b111000,
        op_out  = 6'b101000,
        op_in   = 6'b101001
    } opcode_e;

    // Instruction class from the top opcode bits
    typedef enum logic [2:0] {
        class_alu,
        class_load,
        class_outi,
        class_io,
        class_flow
    } op_class_e;

    typedef enum logic {
        st_run,
        st_skip
    } seq_state_e;

    typedef struct packed {
        logic [CTRL_SPARE_W-1:0]  spare;
        logic [ALU_OP_W-1:0]      alu_op;
        logic                     fin_interrupt;
        logic [NUM_OUT_PORTS-1:0] out_we;
        logic                     sel_out;
        logic                     sel_in;
        logic                     pop;
        logic                     push;
        logic                     sp_we;
        logic                     n_we;
        logic                     z_we;
        logic                     reg_we;
        logic                     sel_imm;
        logic                     pc_inc;   // 1 = PC + 1, 0 = jump target
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

    // Only advance the PC
    localparam ctrl_word_t CTRL_ADVANCE = '{
        pc_inc:  1'b1,
        default: '0
    };

endpackage

//--- hdl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  logic                         rst,
    input  logic [cu_pkg::OPCODE_W-1:0]  opcode,
    input  logic                         z,
    input  logic                         n,
    input  logic                         irq,
    input  logic [cu_pkg::PORT_W-1:0]    port,
    input  logic                         skip_active,
    output cu_pkg::ctrl_word_t           ctrl,
    output logic                         skip_req
);

    import cu_pkg::*;

    // Interrupt entry pushes the return address
    localparam ctrl_word_t CTRL_IRQ = '{
        sp_we:   1'b1,
        push:    1'b1,
        default: '0
    };

    opcode_e                  op;
    op_class_e                op_class;
    logic [NUM_OUT_PORTS-1:0] port_we;
    ctrl_word_t               dec;

    assign op = opcode_e'(opcode);

    // 0xxxxx ALU, 11xxxx flow, 101xxx I/O, 1001xx OUTI, 1000xx LOAD
    always_comb
    begin
        if (!opcode[OPCODE_W-1])
        begin
            op_class = class_alu;
        end
        else if (opcode[OPCODE_W-2])
        begin
            op_class = class_flow;
        end
        else if (opcode[OPCODE_W-3])
        begin
            op_class = class_io;
        end
        else if (opcode[OPCODE_W-4])
        begin
            op_class = class_outi;
        end
        else
        begin
            op_class = class_load;
        end
    end

    // Out-of-range port numbers enable nothing
    always_comb
    begin
        for (int i = 0; i < NUM_OUT_PORTS; i++)
        begin
            port_we[i] = (port == PORT_W'(i));
        end
    end

    always_comb
    begin
        dec = CTRL_ADVANCE;
        case (op_class)
            class_alu:
            begin
                dec.reg_we = 1'b1;
                dec.z_we   = 1'b1;
                dec.n_we   = 1'b1;
                dec.alu_op = opcode[OPCODE_W-2 -: ALU_OP_W];
            end
            class_load:
            begin
                dec.sel_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            class_outi:
            begin
                dec.sel_imm = 1'b1;
                dec.sel_out = 1'b1;
                dec.out_we  = port_we;
            end
            class_io:
            begin
                case (op)
                    op_out:
                    begin
                        dec.sel_out = 1'b1;
                        dec.out_we  = port_we;
                    end
                    op_in:
                    begin
                        dec.reg_we = 1'b1;
                        dec.sel_in = 1'b1;
                    end
                    default:
                    begin
                        dec = CTRL_ADVANCE;
                    end
                endcase
            end
            class_flow:
            begin
                case (op)
                    op_jmp:
                    begin
                        dec = CTRL_IDLE;
                    end
                    op_jz:
                    begin
                        dec.pc_inc = !z;
                    end
                    op_jnz:
                    begin
                        dec.pc_inc = z;
                    end
                    op_jn:
                    begin
                        dec.pc_inc = !n;
                    end
                    op_call:
                    begin
                        dec.sp_we = 1'b1;
                        dec.push  = 1'b1;
                    end
                    op_ret:
                    begin
                        dec        = CTRL_IDLE;
                        dec.sp_we  = 1'b1;
                        dec.pop    = 1'b1;
                    end
                    op_reti:
                    begin
                        dec               = CTRL_IDLE;
                        dec.pop           = 1'b1;
                        dec.fin_interrupt = 1'b1;
                    end
                    // Skip opcodes only advance here
                    default:
                    begin
                        dec = CTRL_ADVANCE;
                    end
                endcase
            end
            default:
            begin
                dec = CTRL_ADVANCE;
            end
        endcase
    end

    always_comb
    begin
        if (rst)
        begin
            ctrl = CTRL_IDLE;
        end
        else if (irq)
        begin
            ctrl = CTRL_IRQ;
        end
        else if (skip_active)
        begin
            ctrl = CTRL_ADVANCE;
        end
        else
        begin
            ctrl = dec;
        end
    end

    assign skip_req = !irq && !skip_active &&
                      ((op == op_skz && z) || (op == op_sknz && !z));

endmodule

//--- hdl/skip_sequencer.sv
`timescale 1ns/100ps

module skip_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic skip_req,
    input  logic irq,
    input  logic timer_done,
    output logic skip_active,
    output logic timer_start
);

    import cu_pkg::*;

    seq_state_e state;
    seq_state_e state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_run;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_run:
            begin
                if (skip_req)
                begin
                    state_next = st_skip;
                end
            end
            st_skip:
            begin
                // An interrupt cycle never closes the window
                if (timer_done && !irq)
                begin
                    state_next = st_run;
                end
            end
            default:
            begin
                state_next = st_run;
            end
        endcase
    end

    assign timer_start = (state == st_run) && skip_req;
    assign skip_active = (state == st_skip);

endmodule

//--- hdl/skip_timer.sv
`timescale 1ns/100ps

module skip_timer #(
    parameter int SKIP_LEN = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic hold,
    output logic done
);

    localparam int CNT_W = $clog2(SKIP_LEN + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (start)
        begin
            count <= CNT_W'(SKIP_LEN);
        end
        else if (!hold && count != '0)
        begin
            count <= count - 1'b1;
        end
    end

    // Last counted cycle of the window
    assign done = (count == CNT_W'(1)) && !hold;

endmodule

//--- testbench/control_unit_chk.sv
`timescale 1ns/100ps

module control_unit_chk #(
    parameter int SKIP_LEN = 2
) (
    input logic               clk,
    input logic               rst,
    input logic               irq,
    input logic               skip_active,
    input cu_pkg::ctrl_word_t ctrl
);

    import cu_pkg::*;

    seq_state_e seq_state;
    int         skip_cnt;
    int         fail_count = 0;

    assign seq_state = skip_active ? st_skip : st_run;

    // Counted cycles of the current skip window
    always_ff @(posedge clk)
    begin
        if (rst || seq_state != st_skip)
        begin
            skip_cnt <= 0;
        end
        else if (!irq)
        begin
            skip_cnt <= skip_cnt + 1;
        end
    end

    push_pop_excl: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.push && ctrl.pop))
        else
        begin
            $error("push and pop high in the same cycle");
            fail_count = fail_count + 1;
        end

    out_we_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ctrl.out_we))
        else
        begin
            $error("more than one output port enabled");
            fail_count = fail_count + 1;
        end

    out_we_sel: assert property (@(posedge clk) disable iff (rst)
        (ctrl.out_we != '0) |-> ctrl.sel_out)
        else
        begin
            $error("output port enabled without sel_out");
            fail_count = fail_count + 1;
        end

    skip_leave: assert property (@(posedge clk) disable iff (rst)
        (seq_state == st_skip && !irq && skip_cnt == SKIP_LEN - 1) |=> seq_state == st_run)
        else
        begin
            $error("skip window did not close after SKIP_LEN counted cycles");
            fail_count = fail_count + 1;
        end

    skip_stay: assert property (@(posedge clk) disable iff (rst)
        (seq_state == st_skip && (irq || skip_cnt < SKIP_LEN - 1)) |=> seq_state == st_skip)
        else
        begin
            $error("skip window closed early");
            fail_count = fail_count + 1;
        end

endmodule

bind control_unit control_unit_chk #(
    .SKIP_LEN (SKIP_LEN)
) u_chk (
    .clk         (clk),
    .rst         (rst),
    .irq         (irq),
    .skip_active (skip_active),
    .ctrl        (ctrl)
);

//--- testbench/control_unit_tb.sv
`timescale 1ns/100ps

module control_unit_tb;

    import cu_pkg::*;

    localparam int SKIP_LEN = 2;

    typedef struct packed {
        logic                rst;
        logic                irq;
        logic [OPCODE_W-1:0] opcode;
        logic                z;
        logic                n;
        logic [PORT_W-1:0]   port;
        ctrl_word_t          exp;
        int                  test;
    } row_t;

    logic                clk;
    logic                rst;
    logic                irq;
    logic [OPCODE_W-1:0] opcode;
    logic                z;
    logic                n;
    logic [PORT_W-1:0]   port;
    ctrl_word_t          ctrl;

    row_t rows[$];
    int   cycles = 0;
    int   cycle_limit = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;

    control_unit #(
        .SKIP_LEN (SKIP_LEN)
    ) UUT (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .z      (z),
        .n      (n),
        .irq    (irq),
        .port   (port),
        .ctrl   (ctrl)
    );

    initial
    begin
        clk = 1'b1;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the stimulus table never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Non-flow words by instruction class; is_in picks IN over OUT in the I/O class
    function automatic ctrl_word_t data_word(op_class_e cls, logic [ALU_OP_W-1:0] alu,
                                             logic [PORT_W-1:0] p, logic is_in);
        ctrl_word_t w;
        w         = CTRL_ADVANCE;
        w.sel_imm = (cls == class_load) || (cls == class_outi);
        w.reg_we  = (cls == class_alu) || (cls == class_load) || (cls == class_io && is_in);
        w.z_we    = (cls == class_alu);
        w.n_we    = (cls == class_alu);
        w.alu_op  = (cls == class_alu) ? alu : '0;
        w.sel_in  = (cls == class_io) && is_in;
        w.sel_out = (cls == class_outi) || (cls == class_io && !is_in);
        if (w.sel_out && p < NUM_OUT_PORTS)
        begin
            w.out_we = NUM_OUT_PORTS'(1) << p;
        end
        return w;
    endfunction

    function automatic ctrl_word_t flow_word(logic inc, logic spw, logic psh, logic pp,
                                             logic fin);
        ctrl_word_t w;
        w               = CTRL_IDLE;
        w.pc_inc        = inc;
        w.sp_we         = spw;
        w.push          = psh;
        w.pop           = pp;
        w.fin_interrupt = fin;
        return w;
    endfunction

    function automatic logic [OPCODE_W-1:0] class_opcode(op_class_e cls, logic [4:0] low);
        if (cls == class_alu)
        begin
            return {1'b0, low};
        end
        return {3'b100, cls == class_outi, low[1:0]};
    endfunction

    task automatic add_row(int t, logic r, logic i, logic [OPCODE_W-1:0] op, logic zz,
                           logic nn, logic [PORT_W-1:0] p, ctrl_word_t e);
        rows.push_back('{rst: r, irq: i, opcode: op, z: zz, n: nn, port: p, exp: e, test: t});
    endtask

    // Random ALU instruction; in_skip expects the advance-only word
    task automatic add_alu(int t, logic i, logic in_skip);
        logic [ALU_OP_W-1:0] alu;
        ctrl_word_t          e;
        alu = ALU_OP_W'($urandom());
        e   = i ? flow_word(0, 1, 1, 0, 0) :
              in_skip ? CTRL_ADVANCE : data_word(class_alu, alu, 0, 0);
        add_row(t, 0, i, class_opcode(class_alu, {alu, 2'($urandom())}), 1'($urandom()),
                1'($urandom()), PORT_W'($urandom()), e);
    endtask

    task automatic build_table();
        logic [PORT_W-1:0] p;
        for (int k = 0; k < 3; k++)
        begin
            add_row(1, 1, 1'($urandom()), OPCODE_W'($urandom()), 1, 1, 4'hf, CTRL_IDLE);
        end
        for (int k = 0; k < 6; k++)
        begin
            add_alu(2, 0, 0);
        end
        add_row(2, 0, 0, class_opcode(class_load, 5'd3), 0, 0, 0, data_word(class_load, 0, 0, 0));
        add_row(2, 0, 0, op_in, 1, 0, 2, data_word(class_io, 0, 2, 1));
        for (int k = 0; k < 6; k++)
        begin
            p = (k < 5) ? PORT_W'(k) : PORT_W'(NUM_OUT_PORTS + $urandom_range(11));
            add_row(3, 0, 0, op_out, 0, 0, p, data_word(class_io, 0, p, 0));
            add_row(3, 0, 0, class_opcode(class_outi, 5'($urandom())), 0, 0, p,
                    data_word(class_outi, 0, p, 0));
        end
        add_row(4, 0, 0, op_jmp, 1'($urandom()), 1'($urandom()), 0, flow_word(0, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jz, 0, 1'($urandom()), 0, flow_word(1, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jz, 1, 1'($urandom()), 0, flow_word(0, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jnz, 0, 1'($urandom()), 0, flow_word(0, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jnz, 1, 1'($urandom()), 0, flow_word(1, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jn, 1'($urandom()), 0, 0, flow_word(1, 0, 0, 0, 0));
        add_row(4, 0, 0, op_jn, 1'($urandom()), 1, 0, flow_word(0, 0, 0, 0, 0));
        add_row(4, 0, 0, op_call, 0, 0, 0, flow_word(1, 1, 1, 0, 0));
        add_row(4, 0, 0, op_ret, 0, 0, 0, flow_word(0, 1, 0, 1, 0));
        add_row(4, 0, 0, op_reti, 0, 0, 0, flow_word(0, 0, 0, 1, 1));
        // Taken skips blank two instructions, untaken ones none
        add_row(5, 0, 0, op_skz, 1, 0, 0, CTRL_ADVANCE);
        add_alu(5, 0, 1);
        add_alu(5, 0, 1);
        add_alu(5, 0, 0);
        add_row(5, 0, 0, op_skz, 0, 0, 0, CTRL_ADVANCE);
        add_alu(5, 0, 0);
        add_row(5, 0, 0, op_sknz, 1, 0, 0, CTRL_ADVANCE);
        add_alu(5, 0, 0);
        add_row(5, 0, 0, op_sknz, 0, 0, 0, CTRL_ADVANCE);
        add_alu(5, 0, 1);
        add_alu(5, 0, 1);
        add_alu(5, 0, 0);
        add_alu(6, 1, 0);
        add_row(6, 0, 1, op_skz, 1, 0, 0, flow_word(0, 1, 1, 0, 0));
        add_alu(6, 0, 0);
        add_row(6, 0, 0, op_skz, 1, 0, 0, CTRL_ADVANCE);
        add_alu(6, 0, 1);
        add_alu(6, 1, 1);
        add_alu(6, 0, 1);
        add_alu(6, 0, 0);
    endtask

    task automatic check_row(row_t r, inout int errs);
        assert (ctrl === r.exp)
        else
        begin
            $display("mismatch at %0t: ctrl expected %h, got %h", $time, r.exp, ctrl);
            errs++;
        end
    endtask

    task automatic report_test(int t, int checks, int errs);
        $display("test %0d finished: %0d checks, %0d errors", t, checks, errs);
        if (errs == 0)
        begin
            tests_passed++;
        end
        else
        begin
            tests_failed++;
        end
    endtask

    initial
    begin
        int cur_test;
        int checks;
        int errs;
        rst    = 1'b1;
        irq    = 1'b0;
        opcode = '0;
        z      = 1'b0;
        n      = 1'b0;
        port   = '0;
        void'($urandom(32'h4f86cdfe));
        build_table();
        cycle_limit = rows.size() + 20;
        cur_test    = rows[0].test;
        checks      = 0;
        errs        = 0;
        foreach (rows[i])
        begin
            if (rows[i].test != cur_test)
            begin
                report_test(cur_test, checks, errs);
                cur_test = rows[i].test;
                checks   = 0;
                errs     = 0;
            end
            @(negedge clk);
            rst    = rows[i].rst;
            irq    = rows[i].irq;
            opcode = rows[i].opcode;
            z      = rows[i].z;
            n      = rows[i].n;
            port   = rows[i].port;
            #40;
            check_row(rows[i], errs);
            checks++;
        end
        report_test(cur_test, checks, errs);
        $display("passing tests: %0d, failing tests: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, UUT.u_chk.fail_count);
        if (tests_failed == 0 && UUT.u_chk.fail_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
